/* source/fifo_pkg.sv */
// frame FIFO geometry
// memory address width and depth
// byte width of the stored word
// full-memory policy flag
`default_nettype none

package fifo_pkg;

    // 64 entries
    localparam int addr_width = 6;

    // one byte per entry, last flag stored beside it
    localparam int data_width = 8;

    // 0 holds in_ready low while full
    // 1 drops the frame instead
    localparam logic drop_when_full = 1'b0;

endpackage

`default_nettype wire

/* source/frame_pkg.sv */
// frame header views, data and command
// header union over one byte
// kind bit values
// parser state encoding and length width
`default_nettype none

package frame_pkg;

    // payload length width, also the counter width
    localparam int len_width = 7;

    // kind bit values, msb of the header
    localparam logic kind_data = 1'b0;
    localparam logic kind_cmd  = 1'b1;

    // data header: length of the payload that follows
    typedef struct packed {
        logic                 kind;
        logic [len_width-1:0] payload_len;
    } data_hdr_t;

    // command header: complete frame in one byte
    typedef struct packed {
        logic       kind;
        logic [2:0] opcode;
        logic [3:0] operand;
    } cmd_hdr_t;

    // same byte, two readings
    // kind sits in bit 7 in both
    typedef union packed {
        data_hdr_t data;
        cmd_hdr_t  cmd;
    } frame_header_t;

    typedef enum logic [2:0] {
        idle    = 3'd0,
        payload = 3'd1,
        check   = 3'd2,
        discard = 3'd3,
        report  = 3'd4
    } parser_state_t;

endpackage

`default_nettype wire

/* source/async_frame_fifo.sv */
// dual-clock store-and-forward frame FIFO
// speculative write pointer, committed on good frame end
// bad and oversize frames rewound and reported
// gray pointer and reset synchronizers per domain
`timescale 1ns/1ps
`default_nettype none

module async_frame_fifo (
    input  wire                             input_clk,
    input  wire                             output_clk,
    input  wire                             async_rst,
    input  wire  [fifo_pkg::data_width-1:0] in_data,
    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire                             in_last,
    input  wire                             in_user,
    output logic [fifo_pkg::data_width-1:0] fifo_data,
    output logic                            fifo_valid,
    input  wire                             fifo_ready,
    output logic                            fifo_last,
    output logic                            overflow,
    output logic                            bad_frame,
    output logic                            good_frame
);

    // binary to gray
    function automatic logic [fifo_pkg::addr_width:0] to_gray(
        input logic [fifo_pkg::addr_width:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

    // last flag stored above the byte
    logic [fifo_pkg::data_width:0] mem [2**fifo_pkg::addr_width];

    // write domain pointers
    logic [fifo_pkg::addr_width:0] wr_ptr;
    logic [fifo_pkg::addr_width:0] wr_ptr_cur;
    logic [fifo_pkg::addr_width:0] wr_ptr_cur_inc;
    logic [fifo_pkg::addr_width:0] wr_ptr_gray;
    logic [fifo_pkg::addr_width:0] wr_cur_gray;
    logic [fifo_pkg::addr_width:0] rd_gray_sync1;
    logic [fifo_pkg::addr_width:0] rd_gray_sync2;

    // read domain pointers
    logic [fifo_pkg::addr_width:0] rd_ptr;
    logic [fifo_pkg::addr_width:0] rd_ptr_gray;
    logic [fifo_pkg::addr_width:0] wr_gray_sync1;
    logic [fifo_pkg::addr_width:0] wr_gray_sync2;

    logic [1:0] in_rst_sync;
    logic [1:0] out_rst_sync;
    logic       in_rst;
    logic       out_rst;

    logic                          drop_frame;
    logic                          full;
    logic                          full_cur;
    logic                          accept;
    logic                          drop_now;
    logic                          empty;
    logic                          read_en;
    logic [fifo_pkg::data_width:0] out_word;

    // async assert, sync release in each domain
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_sync <= 2'b11;
        end else begin
            in_rst_sync <= {in_rst_sync[0], 1'b0};
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_sync <= 2'b11;
        end else begin
            out_rst_sync <= {out_rst_sync[0], 1'b0};
        end
    end

    assign in_rst  = in_rst_sync[1];
    assign out_rst = out_rst_sync[1];

    assign wr_ptr_cur_inc = wr_ptr_cur + 1'b1;
    assign wr_cur_gray    = to_gray(wr_ptr_cur);

    // full against the speculative pointer
    // top two gray bits inverted, rest equal
    assign full = (wr_cur_gray[fifo_pkg::addr_width -: 2] ==
                   ~rd_gray_sync2[fifo_pkg::addr_width -: 2]) &&
                  (wr_cur_gray[fifo_pkg::addr_width-2:0] ==
                   rd_gray_sync2[fifo_pkg::addr_width-2:0]);

    // current frame alone fills the whole memory
    assign full_cur = (wr_ptr[fifo_pkg::addr_width] != wr_ptr_cur[fifo_pkg::addr_width]) &&
                      (wr_ptr[fifo_pkg::addr_width-1:0] == wr_ptr_cur[fifo_pkg::addr_width-1:0]);

    // oversize frame keeps ready high and is swallowed
    assign in_ready = ~full | full_cur | drop_frame | fifo_pkg::drop_when_full;
    assign accept   = in_valid & in_ready;
    assign drop_now = drop_frame | full;

    always_ff @(posedge input_clk) begin
        if (accept && !drop_now) begin
            mem[wr_ptr_cur[fifo_pkg::addr_width-1:0]] <= {in_last, in_data};
        end
    end

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            wr_ptr      <= '0;
            wr_ptr_cur  <= '0;
            wr_ptr_gray <= '0;
            drop_frame  <= 1'b0;
            overflow    <= 1'b0;
            bad_frame   <= 1'b0;
            good_frame  <= 1'b0;
        end else begin
            // status flags are single pulses
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;
            if (accept && drop_now) begin
                // no room, swallow rest of frame
                drop_frame <= 1'b1;
                if (in_last) begin
                    wr_ptr_cur <= wr_ptr;
                    drop_frame <= 1'b0;
                    overflow   <= 1'b1;
                end
            end else if (accept) begin
                wr_ptr_cur <= wr_ptr_cur_inc;
                if (in_last && in_user) begin
                    // source flagged it, rewind
                    wr_ptr_cur <= wr_ptr;
                    bad_frame  <= 1'b1;
                end else if (in_last) begin
                    // publish whole frame to the read side
                    wr_ptr      <= wr_ptr_cur_inc;
                    wr_ptr_gray <= to_gray(wr_ptr_cur_inc);
                    good_frame  <= 1'b1;
                end
            end
        end
    end

    // read pointer into write domain
    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    // committed write pointer into read domain
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

    assign empty   = (rd_ptr_gray == wr_gray_sync2);
    // fetch when output register is free or being drained
    assign read_en = (fifo_ready | ~fifo_valid) & ~empty;

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            fifo_valid  <= 1'b0;
        end else begin
            if (read_en) begin
                rd_ptr      <= rd_ptr + 1'b1;
                rd_ptr_gray <= to_gray(rd_ptr + 1'b1);
            end
            // valid holds while ready is low
            if (fifo_ready || !fifo_valid) begin
                fifo_valid <= ~empty;
            end
        end
    end

    always_ff @(posedge output_clk) begin
        if (read_en) begin
            out_word <= mem[rd_ptr[fifo_pkg::addr_width-1:0]];
        end
    end

    assign {fifo_last, fifo_data} = out_word;

endmodule

`default_nettype wire

/* source/payload_counter.sv */
// remaining payload byte counter
// load from header, decrement per byte, saturate at zero
`timescale 1ns/1ps
`default_nettype none

module payload_counter (
    input  wire                           output_clk,
    input  wire                           async_rst,
    input  wire                           cnt_load,
    input  wire  [frame_pkg::len_width-1:0] load_value,
    input  wire                           cnt_dec,
    output logic                          cnt_zero
);

    logic [frame_pkg::len_width-1:0] count;

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= load_value;
        end else if (cnt_dec && !cnt_zero) begin
            // never wraps below zero
            count <= count - 1'b1;
        end
    end

    assign cnt_zero = (count == '0);

endmodule

`default_nettype wire

/* source/checksum_accumulator.sv */
// modulo-256 running payload sum
// combinational compare with the incoming checksum byte
`timescale 1ns/1ps
`default_nettype none

module checksum_accumulator (
    input  wire                             output_clk,
    input  wire                             async_rst,
    input  wire                             sum_clear,
    input  wire                             sum_add,
    input  wire  [fifo_pkg::data_width-1:0] byte_in,
    output logic                            sum_match
);

    logic [fifo_pkg::data_width-1:0] sum;

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            sum <= '0;
        end else if (sum_clear) begin
            sum <= '0;
        end else if (sum_add) begin
            // carry out dropped, modulo 256
            sum <= sum + byte_in;
        end
    end

    // only meaningful on the check byte
    assign sum_match = (sum == byte_in);

endmodule

`default_nettype wire

/* source/frame_parser_fsm.sv */
// frame parser FSM on the output side
// header decode, payload streaming, checksum judgement
// registered payload, command and frame result strobes
`timescale 1ns/1ps
`default_nettype none

module frame_parser_fsm (
    input  wire                             output_clk,
    input  wire                             async_rst,
    input  wire  [fifo_pkg::data_width-1:0] fifo_data,
    input  wire                             fifo_valid,
    input  wire                             fifo_last,
    output logic                            fifo_ready,
    output logic                            cnt_load,
    output logic                            cnt_dec,
    input  wire                             cnt_zero,
    output logic                            sum_clear,
    output logic                            sum_add,
    input  wire                             sum_match,
    output logic [fifo_pkg::data_width-1:0] payload_data,
    output logic                            payload_valid,
    output logic                            cmd_valid,
    output logic [2:0]                      cmd_opcode,
    output logic [3:0]                      cmd_operand,
    output logic                            frame_good,
    output logic                            frame_bad
);

    frame_pkg::parser_state_t state;
    frame_pkg::parser_state_t state_next;
    frame_pkg::frame_header_t hdr;

    logic xfer;
    logic is_hdr;
    logic is_cmd;
    logic is_data;
    logic len_zero;
    logic is_payload;
    logic is_check;
    logic good_next;
    logic bad_next;

    assign hdr        = fifo_data;
    assign fifo_ready = (state != frame_pkg::report);
    assign xfer       = fifo_valid & fifo_ready;

    assign is_hdr   = xfer & (state == frame_pkg::idle);
    assign is_cmd   = is_hdr & (hdr.cmd.kind == frame_pkg::kind_cmd);
    assign is_data  = is_hdr & (hdr.data.kind == frame_pkg::kind_data);
    assign len_zero = (hdr.data.payload_len == {frame_pkg::len_width{1'b0}});

    // count spent in payload state, so this byte is the checksum
    assign is_payload = xfer & (state == frame_pkg::payload) & ~cnt_zero;
    assign is_check   = xfer & ((state == frame_pkg::check) |
                                ((state == frame_pkg::payload) & cnt_zero));

    assign cnt_load  = is_data;
    assign sum_clear = is_data;
    assign cnt_dec   = is_payload;
    assign sum_add   = is_payload;

    // a data header with last, or last inside the payload, is short
    assign good_next = (is_cmd & fifo_last) | (is_check & fifo_last & sum_match);
    assign bad_next  = (is_data & fifo_last) |
                       (is_payload & fifo_last) |
                       (is_check & fifo_last & ~sum_match) |
                       (xfer & (state == frame_pkg::discard) & fifo_last);

    always_comb begin
        state_next = state;
        if (good_next || bad_next) begin
            state_next = frame_pkg::report;
        end else if (is_cmd || is_check) begin
            // no last where one was due
            state_next = frame_pkg::discard;
        end else if (is_data) begin
            state_next = len_zero ? frame_pkg::check : frame_pkg::payload;
        end else if (state == frame_pkg::report) begin
            state_next = frame_pkg::idle;
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            state         <= frame_pkg::idle;
            payload_valid <= 1'b0;
            cmd_valid     <= 1'b0;
            frame_good    <= 1'b0;
            frame_bad     <= 1'b0;
        end else begin
            state         <= state_next;
            payload_valid <= is_payload;
            cmd_valid     <= is_cmd & fifo_last;
            frame_good    <= good_next;
            frame_bad     <= bad_next;
        end
    end

    // field registers, qualified by the strobes
    always_ff @(posedge output_clk) begin
        if (is_payload) begin
            payload_data <= fifo_data;
        end
        if (is_cmd) begin
            cmd_opcode  <= hdr.cmd.opcode;
            cmd_operand <= hdr.cmd.operand;
        end
    end

endmodule

`default_nettype wire

/* source/frame_rx_top.sv */
// frame receiver top level
// frame FIFO, parser FSM, payload counter, checksum
`timescale 1ns/1ps
`default_nettype none

module frame_rx_top (
    input  wire                             input_clk,
    input  wire                             output_clk,
    input  wire                             async_rst,
    input  wire  [fifo_pkg::data_width-1:0] in_data,
    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire                             in_last,
    input  wire                             in_user,
    output logic [fifo_pkg::data_width-1:0] payload_data,
    output logic                            payload_valid,
    output logic                            cmd_valid,
    output logic [2:0]                      cmd_opcode,
    output logic [3:0]                      cmd_operand,
    output logic                            frame_good,
    output logic                            frame_bad,
    output logic                            fifo_overflow,
    output logic                            fifo_bad_frame,
    output logic                            fifo_good_frame
);

    // FIFO to parser, output_clk domain
    logic [fifo_pkg::data_width-1:0] fifo_data;
    logic                            fifo_valid;
    logic                            fifo_ready;
    logic                            fifo_last;

    logic cnt_load;
    logic cnt_dec;
    logic cnt_zero;
    logic sum_clear;
    logic sum_add;
    logic sum_match;

    async_frame_fifo fifo_i (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_last    (in_last),
        .in_user    (in_user),
        .fifo_data  (fifo_data),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .fifo_last  (fifo_last),
        .overflow   (fifo_overflow),
        .bad_frame  (fifo_bad_frame),
        .good_frame (fifo_good_frame)
    );

    frame_parser_fsm parser_i (
        .output_clk    (output_clk),
        .async_rst     (async_rst),
        .fifo_data     (fifo_data),
        .fifo_valid    (fifo_valid),
        .fifo_last     (fifo_last),
        .fifo_ready    (fifo_ready),
        .cnt_load      (cnt_load),
        .cnt_dec       (cnt_dec),
        .cnt_zero      (cnt_zero),
        .sum_clear     (sum_clear),
        .sum_add       (sum_add),
        .sum_match     (sum_match),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .cmd_valid     (cmd_valid),
        .cmd_opcode    (cmd_opcode),
        .cmd_operand   (cmd_operand),
        .frame_good    (frame_good),
        .frame_bad     (frame_bad)
    );

    // header length field is the low bits of the byte
    payload_counter counter_i (
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .cnt_load   (cnt_load),
        .load_value (fifo_data[frame_pkg::len_width-1:0]),
        .cnt_dec    (cnt_dec),
        .cnt_zero   (cnt_zero)
    );

    checksum_accumulator checksum_i (
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .sum_clear  (sum_clear),
        .sum_add    (sum_add),
        .byte_in    (fifo_data),
        .sum_match  (sum_match)
    );

endmodule

`default_nettype wire

/* tb/tb_frame_rx_top.sv */
// testbench for the frame receiver top level
// frame table builder with random payloads and computed checksums
// byte sender with random valid gaps, output and FIFO status monitors
// in-order compare against the table, watchdog sized by frame count
`timescale 1ns/1ps
`default_nettype none

module tb_frame_rx_top;

    localparam int num_frames = 13;
    localparam int max_bytes  = 80;

    // FIFO status as {fifo_overflow, fifo_bad_frame, fifo_good_frame}
    localparam logic [2:0] f_good = 3'b001;
    localparam logic [2:0] f_bad  = 3'b010;
    localparam logic [2:0] f_over = 3'b100;
    // parser result as {frame_bad, frame_good}, zero when none is due
    localparam logic [1:0] p_good = 2'b01;
    localparam logic [1:0] p_bad  = 2'b10;
    localparam logic [1:0] p_none = 2'b00;
    // data frame build modes
    localparam int m_good    = 0;
    localparam int m_bad_sum = 1;
    localparam int m_short   = 2;
    localparam int m_extra   = 3;
    localparam int m_user    = 4;

    logic       input_clk  = 1'b0;
    logic       output_clk = 1'b0;
    logic       async_rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_last;
    logic       in_user;
    wire        in_ready;
    wire  [7:0] payload_data;
    wire        payload_valid;
    wire        cmd_valid;
    wire  [2:0] cmd_opcode;
    wire  [3:0] cmd_operand;
    wire        frame_good;
    wire        frame_bad;
    wire        fifo_overflow;
    wire        fifo_bad_frame;
    wire        fifo_good_frame;

    // frame table, payload bytes sit right after the header
    logic [7:0] frm_bytes [num_frames][max_bytes];
    int         frm_len   [num_frames];
    logic       frm_user  [num_frames];
    logic [2:0] exp_fifo  [num_frames];
    logic [1:0] exp_parse [num_frames];
    logic       exp_has_cmd [num_frames];
    logic [6:0] exp_cmd   [num_frames];
    int         exp_pay_n [num_frames];
    int         nf = 0;

    // expected and observed streams, frame order
    logic [7:0] want_pay[$];
    logic [7:0] want_cmd[$];
    logic [7:0] want_res[$];
    logic [7:0] want_fifo[$];
    logic [7:0] got_pay[$];
    logic [7:0] got_cmd[$];
    logic [7:0] got_res[$];
    logic [7:0] got_fifo[$];

    // set once the full memory has held in_ready low
    logic ready_low_seen = 1'b0;

    int value_errors = 0;
    int other_errors = 0;

    // unrelated clocks
    always #20 output_clk = ~output_clk;
    always #14 input_clk  = ~input_clk;

    frame_rx_top dut_i (
        .input_clk       (input_clk),
        .output_clk      (output_clk),
        .async_rst       (async_rst),
        .in_data         (in_data),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_last         (in_last),
        .in_user         (in_user),
        .payload_data    (payload_data),
        .payload_valid   (payload_valid),
        .cmd_valid       (cmd_valid),
        .cmd_opcode      (cmd_opcode),
        .cmd_operand     (cmd_operand),
        .frame_good      (frame_good),
        .frame_bad       (frame_bad),
        .fifo_overflow   (fifo_overflow),
        .fifo_bad_frame  (fifo_bad_frame),
        .fifo_good_frame (fifo_good_frame)
    );

    // source flag first, then the 64-entry memory limit
    function automatic logic [2:0] fifo_outcome(input int len, input logic user);
        if (user) begin
            return f_bad;
        end
        if (len > 64) begin
            return f_over;
        end
        return f_good;
    endfunction

    // single-byte command, kind bit set
    task automatic add_cmd_frame(input logic [2:0] op, input logic [3:0] arg);
        frm_bytes[nf][0] = {1'b1, op, arg};
        frm_len[nf]      = 1;
        frm_user[nf]     = 1'b0;
        exp_fifo[nf]     = f_good;
        exp_parse[nf]    = p_good;
        exp_has_cmd[nf]  = 1'b1;
        exp_cmd[nf]      = {op, arg};
        exp_pay_n[nf]    = 0;
        nf++;
    endtask

    // header, payload, checksum, shaped by mode
    task automatic add_data_frame(input int n, input int mode);
        logic [7:0] sum;
        int         sent;
        int         k;
        sum  = 8'h00;
        // short frame ends two bytes early, last on a payload byte
        sent = (mode == m_short) ? n - 2 : n;
        frm_bytes[nf][0] = {1'b0, n[6:0]};
        for (k = 1; k <= sent; k++) begin
            frm_bytes[nf][k] = $urandom_range(255, 0);
            sum = sum + frm_bytes[nf][k];
        end
        frm_len[nf] = sent + 1;
        if (mode != m_short) begin
            frm_bytes[nf][sent+1] = (mode == m_bad_sum) ? (sum ^ 8'h5a) : sum;
            frm_len[nf] = sent + 2;
        end
        // trailing byte after a correct checksum
        if (mode == m_extra) begin
            frm_bytes[nf][sent+2] = $urandom_range(255, 0);
            frm_len[nf] = sent + 3;
        end
        frm_user[nf]    = (mode == m_user);
        exp_fifo[nf]    = fifo_outcome(frm_len[nf], frm_user[nf]);
        exp_has_cmd[nf] = 1'b0;
        exp_cmd[nf]     = 7'h00;
        if (exp_fifo[nf] != f_good) begin
            exp_parse[nf] = p_none;
        end else if (mode == m_good) begin
            exp_parse[nf] = p_good;
        end else begin
            exp_parse[nf] = p_bad;
        end
        exp_pay_n[nf] = (exp_fifo[nf] == f_good) ? sent : 0;
        nf++;
    endtask

    // flatten the table into per-output streams
    task automatic build_expected();
        int f;
        int k;
        for (f = 0; f < num_frames; f++) begin
            want_fifo.push_back({5'b0, exp_fifo[f]});
            if (exp_parse[f] != p_none) begin
                want_res.push_back({6'b0, exp_parse[f]});
            end
            if (exp_has_cmd[f] && exp_parse[f] != p_none) begin
                want_cmd.push_back({1'b0, exp_cmd[f]});
            end
            for (k = 1; k <= exp_pay_n[f]; k++) begin
                want_pay.push_back(frm_bytes[f][k]);
            end
        end
    endtask

    // random idle cycles, then hold the byte until in_ready
    task automatic send_byte(input logic [7:0] b, input logic last, input logic user);
        logic done;
        done = 1'b0;
        while ($urandom_range(3, 0) == 0) begin
            @(posedge input_clk);
            in_valid <= 1'b0;
        end
        @(posedge input_clk);
        in_data  <= b;
        in_valid <= 1'b1;
        in_last  <= last;
        in_user  <= user & last;
        // ready is stable between edges, transfer on the next rise
        while (!done) begin
            @(negedge input_clk);
            done = in_ready;
        end
    endtask

    task automatic send_frame(input int f);
        int k;
        for (k = 0; k < frm_len[f]; k++) begin
            send_byte(frm_bytes[f][k], k == frm_len[f] - 1, frm_user[f]);
        end
    endtask

    task automatic compare_value(input string name, input logic [7:0] want,
                                 input logic [7:0] got);
        if (want !== got) begin
            $display("** Error %s: expected %h, got %h", name, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_count(input string what, input int want, input int got);
        if (want != got) begin
            $display("wrong number of %s: expected %0d, saw %0d", what, want, got);
            other_errors++;
        end
    endtask

    // parser side outputs, sampled mid-cycle
    always @(negedge output_clk) begin
        if (!async_rst) begin
            if (payload_valid) begin
                got_pay.push_back(payload_data);
            end
            if (cmd_valid) begin
                got_cmd.push_back({1'b0, cmd_opcode, cmd_operand});
            end
            if (frame_good || frame_bad) begin
                got_res.push_back({6'b0, frame_bad, frame_good});
            end
        end
    end

    // FIFO status pulses and ready level, input side
    always @(negedge input_clk) begin
        if (!async_rst) begin
            if (fifo_good_frame || fifo_bad_frame || fifo_overflow) begin
                got_fifo.push_back({5'b0, fifo_overflow, fifo_bad_frame, fifo_good_frame});
            end
            if (in_ready === 1'b0) begin
                ready_low_seen = 1'b1;
            end
        end
    end

    // allowance scales with the number of frames
    initial begin
        repeat (num_frames * 200) @(posedge output_clk);
        $display("timeout: frame results did not arrive in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int seed;
        int f;
        int k;
        seed      = $urandom(52);
        async_rst = 1'b1;
        in_data   = 8'h00;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_user   = 1'b0;

        add_data_frame(6, m_good);
        add_cmd_frame(3'd3, 4'ha);
        add_data_frame(4, m_user);
        add_data_frame(5, m_bad_sum);
        add_data_frame(6, m_short);
        add_data_frame(3, m_extra);
        // 70 bytes, more than the memory holds
        add_data_frame(68, m_good);
        add_data_frame(8, m_good);
        add_data_frame(0, m_good);
        add_cmd_frame(3'd7, 4'h1);
        // 64-byte frame fills the memory, next one waits on in_ready
        add_data_frame(62, m_good);
        add_data_frame(50, m_good);
        add_cmd_frame(3'd0, 4'h0);
        build_expected();

        repeat (5) @(posedge output_clk);
        async_rst <= 1'b0;
        // reset synchronizers inside the FIFO
        repeat (4) @(posedge input_clk);

        for (f = 0; f < num_frames; f++) begin
            send_frame(f);
        end
        @(posedge input_clk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        in_user  <= 1'b0;

        while (got_res.size() < want_res.size() || got_fifo.size() < num_frames) begin
            @(negedge output_clk);
        end
        // quiet time to catch stray strobes
        repeat (50) @(negedge output_clk);

        compare_count("FIFO status pulses", want_fifo.size(), got_fifo.size());
        for (k = 0; k < want_fifo.size() && k < got_fifo.size(); k++) begin
            compare_value("{fifo_overflow,fifo_bad_frame,fifo_good_frame}",
                          want_fifo[k], got_fifo[k]);
        end
        compare_count("frame results", want_res.size(), got_res.size());
        for (k = 0; k < want_res.size() && k < got_res.size(); k++) begin
            compare_value("{frame_bad,frame_good}", want_res[k], got_res[k]);
        end
        compare_count("command pulses", want_cmd.size(), got_cmd.size());
        for (k = 0; k < want_cmd.size() && k < got_cmd.size(); k++) begin
            compare_value("cmd_opcode", want_cmd[k][6:4], got_cmd[k][6:4]);
            compare_value("cmd_operand", want_cmd[k][3:0], got_cmd[k][3:0]);
        end
        compare_count("payload strobes", want_pay.size(), got_pay.size());
        for (k = 0; k < want_pay.size() && k < got_pay.size(); k++) begin
            compare_value("payload_data", want_pay[k], got_pay[k]);
        end

        // the full memory must have held the sender off
        if (!ready_low_seen) begin
            $display("in_ready never went low while the memory was full");
            other_errors++;
        end

        // output side drained, space must be back
        @(negedge input_clk);
        compare_value("in_ready", 8'h01, {7'b0, in_ready});

        $display("checks done: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/fifo_pkg.sv
source/frame_pkg.sv
source/async_frame_fifo.sv
source/payload_counter.sv
source/checksum_accumulator.sv
source/frame_parser_fsm.sv
source/frame_rx_top.sv
tb/tb_frame_rx_top.sv

/* Bender.yml */
package:
  name: frame_rx

sources:
  - source/fifo_pkg.sv
  - source/frame_pkg.sv
  - source/async_frame_fifo.sv
  - source/payload_counter.sv
  - source/checksum_accumulator.sv
  - source/frame_parser_fsm.sv
  - source/frame_rx_top.sv
  - target: test
    files:
      - tb/tb_frame_rx_top.sv
